// File: files.f
+incdir+include
rtl/l2_types_pkg.sv
rtl/l2_ctrl_pkg.sv
rtl/l2_reqs_if.sv
rtl/l2_regs.sv
rtl/l2_reqs.sv
rtl/l2_ctrl.sv
rtl/l2_top.sv
verification/l2_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module l2_tb -o l2_sim

./obj_dir/l2_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run finished without failures"

// File: verification/l2_tb.sv
`include "cache_consts.svh"

module l2_tb
    import l2_types_pkg::*;
    import l2_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NSTEPS = 23;
    localparam int STALL_CYCLES = 6;
    localparam int ACK_LIMIT = 50;
    localparam int FLUSH_LIMIT = `L2_SETS * `L2_WAYS * 10;
    localparam int WATCHDOG_CYCLES = NSTEPS * 200 + FLUSH_LIMIT;

    typedef enum logic [1:0] {
        CH_CPU,
        CH_FILL,
        CH_FWD,
        CH_FLUSH
    } chan_t;

    typedef struct packed {
        chan_t     chan;
        l2_set_t   val;      // Set for cpu and fwd steps, entry index for fill steps.
        cpu_op_t   op;
        reqs_idx_t exp_idx;  // Entry the CPU request is expected to get.
        logic      stall;
    } step_t;

    logic      clk;
    logic      rst;
    logic      cpu_req_i;
    l2_set_t   cpu_set_i;
    cpu_op_t   cpu_op_i;
    logic      cpu_ack_o;
    reqs_idx_t cpu_idx_o;
    logic      fill_req_i;
    reqs_idx_t fill_idx_i;
    logic      fill_ack_o;
    logic      fwd_req_i;
    l2_set_t   fwd_set_i;
    logic      fwd_ack_o;
    logic      flush_req_i;
    logic      flush_ack_o;
    logic      evict_req_o;
    l2_set_t   evict_set_o;
    l2_way_t   evict_way_o;
    logic      evict_ack_i;
    reqs_cnt_t reqs_cnt_o;

    step_t            steps [NSTEPS];
    logic [`REQS-1:0] model_valid = '0;  // Entries the model holds as pending.
    int               model_cnt = 0;
    logic             flush_open = 1'b0;
    int               evict_cnt = 0;
    int               checks = 0;
    int               errors = 0;

    l2_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic ack_of(input chan_t c);
        case (c)
            CH_CPU:  return cpu_ack_o;
            CH_FILL: return fill_ack_o;
            CH_FWD:  return fwd_ack_o;
            default: return flush_ack_o;
        endcase
    endfunction

    task automatic wait_ack(input chan_t c, input logic level, input int limit);
        int n;
        n = 0;
        while (ack_of(c) !== level && n < limit) begin
            tick();
            n++;
        end
        if (ack_of(c) !== level) begin
            errors++;
            $display("Timed out waiting for the %s ack to become %0b", c.name(), level);
        end
    endtask

    task automatic drop_req(input chan_t c);
        case (c)
            CH_CPU:  cpu_req_i = 1'b0;
            CH_FILL: fill_req_i = 1'b0;
            CH_FWD:  fwd_req_i = 1'b0;
            default: flush_req_i = 1'b0;
        endcase
    endtask

    task automatic start_req(input step_t st);
        case (st.chan)
            CH_CPU: begin
                cpu_set_i = st.val;
                cpu_op_i  = st.op;
                cpu_req_i = 1'b1;
            end
            CH_FWD: begin
                fwd_set_i = st.val;
                fwd_req_i = 1'b1;
            end
            default: begin
                flush_open  = 1'b1;
                evict_cnt   = 0;
                flush_req_i = 1'b1;
            end
        endcase
    endtask

    task automatic finish_req(input step_t st);
        wait_ack(st.chan, 1'b1, st.chan == CH_FLUSH ? FLUSH_LIMIT : ACK_LIMIT);
        if (st.chan == CH_CPU) begin
            check_val("cpu_idx_o", 32'(cpu_idx_o), 32'(st.exp_idx));
            model_valid[st.exp_idx] = 1'b1;
            model_cnt++;
        end
        if (st.chan == CH_FLUSH) check_val("evictions", evict_cnt, `L2_SETS * `L2_WAYS);
        drop_req(st.chan);
        wait_ack(st.chan, 1'b0, ACK_LIMIT);
        if (st.chan == CH_FLUSH) begin
            flush_open = 1'b0;
            model_cnt  = 0;  // The count restarts once the flush handshake is done.
        end
    endtask

    task automatic hold_stalled(input chan_t c);
        repeat (STALL_CYCLES) begin
            tick();
            check_val({c.name(), " ack"}, 32'(ack_of(c)), 32'h0);
        end
    endtask

    task automatic do_fill(input reqs_idx_t idx);
        fill_idx_i = idx;
        fill_req_i = 1'b1;
        wait_ack(CH_FILL, 1'b1, ACK_LIMIT);
        model_valid[idx] = 1'b0;
        drop_req(CH_FILL);
        wait_ack(CH_FILL, 1'b0, ACK_LIMIT);
    endtask

    task automatic load_steps();
        steps[0]  = '{CH_CPU, 3'd1, OP_READ, 2'd0, 1'b0};
        steps[1]  = '{CH_CPU, 3'd2, OP_READ, 2'd1, 1'b0};
        steps[2]  = '{CH_CPU, 3'd3, OP_READ, 2'd2, 1'b0};
        steps[3]  = '{CH_CPU, 3'd1, OP_READ, 2'd0, 1'b1};   // Set 1 is pending in entry 0.
        steps[4]  = '{CH_FILL, 3'd0, OP_READ, 2'd0, 1'b0};
        steps[5]  = '{CH_CPU, 3'd4, OP_READ, 2'd3, 1'b0};
        steps[6]  = '{CH_CPU, 3'd5, OP_READ, 2'd2, 1'b1};   // Table is full.
        steps[7]  = '{CH_FILL, 3'd2, OP_READ, 2'd0, 1'b0};
        steps[8]  = '{CH_FWD, 3'd6, OP_READ, 2'd0, 1'b0};
        steps[9]  = '{CH_FWD, 3'd2, OP_READ, 2'd0, 1'b1};   // Hits entry 1.
        steps[10] = '{CH_FILL, 3'd3, OP_READ, 2'd0, 1'b1};
        steps[11] = '{CH_FILL, 3'd1, OP_READ, 2'd0, 1'b0};
        steps[12] = '{CH_CPU, 3'd7, OP_ATOMIC, 2'd1, 1'b0};
        steps[13] = '{CH_CPU, 3'd6, OP_READ, 2'd0, 1'b1};
        steps[14] = '{CH_FILL, 3'd0, OP_READ, 2'd0, 1'b1};  // Not the atomic's entry.
        steps[15] = '{CH_FILL, 3'd1, OP_READ, 2'd0, 1'b0};
        steps[16] = '{CH_FLUSH, 3'd0, OP_READ, 2'd0, 1'b1};
        steps[17] = '{CH_FILL, 3'd0, OP_READ, 2'd0, 1'b1};
        steps[18] = '{CH_FILL, 3'd2, OP_READ, 2'd0, 1'b0};
        steps[19] = '{CH_CPU, 3'd0, OP_READ, 2'd0, 1'b0};
        steps[20] = '{CH_FLUSH, 3'd0, OP_READ, 2'd0, 1'b1};
        steps[21] = '{CH_FILL, 3'd0, OP_READ, 2'd0, 1'b0};
        steps[22] = '{CH_FLUSH, 3'd0, OP_READ, 2'd0, 1'b0};
    endtask

    // Answers each eviction after a short random delay and checks the walk order.
    initial begin : evict_responder
        int delay;
        void'($urandom(32'hd57a));
        evict_ack_i = 1'b0;
        forever begin
            tick();
            if (evict_req_o && !evict_ack_i) begin
                checks++;
                assert (flush_open && model_valid == '0) else begin
                    errors++;
                    $display("Eviction issued with no flush running or with requests pending");
                end
                check_val("evict_set_o", 32'(evict_set_o), evict_cnt / `L2_WAYS);
                check_val("evict_way_o", 32'(evict_way_o), evict_cnt % `L2_WAYS);
                evict_cnt++;
                delay = $urandom_range(3, 0);
                repeat (delay) tick();
                evict_ack_i = 1'b1;
                while (evict_req_o) tick();
                evict_ack_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin : main_seq
        step_t cur;
        step_t open_step;
        logic  open_valid;
        rst         = 1'b0;
        cpu_req_i   = 1'b0;
        cpu_set_i   = '0;
        cpu_op_i    = OP_READ;
        fill_req_i  = 1'b0;
        fill_idx_i  = '0;
        fwd_req_i   = 1'b0;
        fwd_set_i   = '0;
        flush_req_i = 1'b0;
        open_valid  = 1'b0;
        open_step   = '0;
        load_steps();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        tick();
        check_val("cpu_ack_o", 32'(cpu_ack_o), 32'h0);
        check_val("fill_ack_o", 32'(fill_ack_o), 32'h0);
        check_val("fwd_ack_o", 32'(fwd_ack_o), 32'h0);
        check_val("flush_ack_o", 32'(flush_ack_o), 32'h0);
        check_val("evict_req_o", 32'(evict_req_o), 32'h0);
        check_val("reqs_cnt_o", 32'(reqs_cnt_o), 32'h0);
        for (int s = 0; s < NSTEPS; s++) begin
            cur = steps[s];
            if (cur.chan == CH_FILL) begin
                do_fill(cur.val[`REQS_BITS-1:0]);
                if (open_valid && cur.stall) begin
                    hold_stalled(open_step.chan);  // The open request must still wait.
                end else if (open_valid) begin
                    finish_req(open_step);
                    open_valid = 1'b0;
                end
            end else begin
                start_req(cur);
                if (cur.stall) begin
                    hold_stalled(cur.chan);
                    open_step  = cur;
                    open_valid = 1'b1;
                end else begin
                    finish_req(cur);
                end
            end
            check_val("reqs_cnt_o", 32'(reqs_cnt_o), model_cnt);
        end
        report_counts();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rtl/l2_top.sv
module l2_top
    import l2_types_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_req_i,
    input  l2_set_t   cpu_set_i,
    input  cpu_op_t   cpu_op_i,
    output logic      cpu_ack_o,
    output reqs_idx_t cpu_idx_o,
    input  logic      fill_req_i,
    input  reqs_idx_t fill_idx_i,
    output logic      fill_ack_o,
    input  logic      fwd_req_i,
    input  l2_set_t   fwd_set_i,
    output logic      fwd_ack_o,
    input  logic      flush_req_i,
    output logic      flush_ack_o,
    output logic      evict_req_o,
    output l2_set_t   evict_set_o,
    output l2_way_t   evict_way_o,
    input  logic      evict_ack_i,
    output reqs_cnt_t reqs_cnt_o
);

    l2_reqs_if reqs_bus ();

    logic      put, set_ongoing_flush, clr_ongoing_flush, set_set_conflict, clr_set_conflict;
    logic      set_fwd_stall, clr_fwd_stall, set_ongoing_atomic, clr_ongoing_atomic;
    logic      set_evict_stall, clr_evict_stall, set_flush_stall_ended, clr_flush_stall_ended;
    logic      incr_flush_set, clr_flush_set, incr_flush_way, clr_flush_way;
    logic      incr_reqs_cnt, clr_reqs_cnt, set_fwd_stall_i, clr_fwd_stall_ended;
    logic      ongoing_flush, set_conflict, fwd_stall, ongoing_atomic;
    logic      evict_stall, flush_stall_ended, fwd_stall_ended;
    reqs_idx_t put_idx;
    reqs_idx_t fwd_stall_i_wr_data;
    l2_set_t   flush_set;
    l2_way_t   flush_way;

    l2_ctrl u_ctrl (
        .clk, .rst,
        .cpu_req_i, .cpu_set_i, .cpu_op_i, .cpu_ack_o, .cpu_idx_o,
        .fwd_req_i, .fwd_set_i, .fwd_ack_o, .flush_req_i, .flush_ack_o,
        .evict_req_o, .evict_set_o, .evict_way_o, .evict_ack_i,
        .reqs(reqs_bus.ctrl), .put_i(put), .put_idx_i(put_idx),
        .set_ongoing_flush_o(set_ongoing_flush), .clr_ongoing_flush_o(clr_ongoing_flush),
        .set_set_conflict_o(set_set_conflict), .clr_set_conflict_o(clr_set_conflict),
        .set_fwd_stall_o(set_fwd_stall), .clr_fwd_stall_o(clr_fwd_stall),
        .set_ongoing_atomic_o(set_ongoing_atomic), .clr_ongoing_atomic_o(clr_ongoing_atomic),
        .set_evict_stall_o(set_evict_stall), .clr_evict_stall_o(clr_evict_stall),
        .set_flush_stall_ended_o(set_flush_stall_ended),
        .clr_flush_stall_ended_o(clr_flush_stall_ended),
        .incr_flush_set_o(incr_flush_set), .clr_flush_set_o(clr_flush_set),
        .incr_flush_way_o(incr_flush_way), .clr_flush_way_o(clr_flush_way),
        .incr_reqs_cnt_o(incr_reqs_cnt), .clr_reqs_cnt_o(clr_reqs_cnt),
        .set_fwd_stall_i_o(set_fwd_stall_i), .fwd_stall_i_wr_data_o(fwd_stall_i_wr_data),
        .clr_fwd_stall_ended_o(clr_fwd_stall_ended),
        .ongoing_flush_i(ongoing_flush), .set_conflict_i(set_conflict),
        .fwd_stall_i(fwd_stall), .ongoing_atomic_i(ongoing_atomic),
        .evict_stall_i(evict_stall), .flush_stall_ended_i(flush_stall_ended),
        .fwd_stall_ended_i(fwd_stall_ended), .flush_set_i(flush_set), .flush_way_i(flush_way)
    );

    l2_regs u_regs (
        .clk, .rst,
        .set_ongoing_flush_i(set_ongoing_flush), .clr_ongoing_flush_i(clr_ongoing_flush),
        .set_set_conflict_i(set_set_conflict), .clr_set_conflict_i(clr_set_conflict),
        .set_fwd_stall_i(set_fwd_stall), .clr_fwd_stall_i(clr_fwd_stall),
        .set_ongoing_atomic_i(set_ongoing_atomic), .clr_ongoing_atomic_i(clr_ongoing_atomic),
        .set_evict_stall_i(set_evict_stall), .clr_evict_stall_i(clr_evict_stall),
        .set_flush_stall_ended_i(set_flush_stall_ended),
        .clr_flush_stall_ended_i(clr_flush_stall_ended),
        .incr_flush_set_i(incr_flush_set), .clr_flush_set_i(clr_flush_set),
        .incr_flush_way_i(incr_flush_way), .clr_flush_way_i(clr_flush_way),
        .incr_reqs_cnt_i(incr_reqs_cnt), .clr_reqs_cnt_i(clr_reqs_cnt),
        .set_fwd_stall_i_i(set_fwd_stall_i), .fwd_stall_i_wr_data_i(fwd_stall_i_wr_data),
        .clr_fwd_stall_ended_i(clr_fwd_stall_ended), .put_i(put), .put_idx_i(put_idx),
        .ongoing_flush_o(ongoing_flush), .set_conflict_o(set_conflict),
        .fwd_stall_o(fwd_stall), .ongoing_atomic_o(ongoing_atomic),
        .evict_stall_o(evict_stall), .flush_stall_ended_o(flush_stall_ended),
        .fwd_stall_ended_o(fwd_stall_ended), .flush_set_o(flush_set),
        .flush_way_o(flush_way), .reqs_cnt_o
    );

    l2_reqs u_reqs (
        .clk, .rst,
        .reqs(reqs_bus.tbl),
        .fill_req_i, .fill_idx_i, .fill_ack_o,
        .put_o(put), .put_idx_o(put_idx)
    );

endmodule

// File: rtl/l2_ctrl.sv
`include "cache_consts.svh"

module l2_ctrl
    import l2_types_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      cpu_req_i,
    input  l2_set_t   cpu_set_i,
    input  cpu_op_t   cpu_op_i,
    output logic      cpu_ack_o,
    output reqs_idx_t cpu_idx_o,
    input  logic      fwd_req_i,
    input  l2_set_t   fwd_set_i,
    output logic      fwd_ack_o,
    input  logic      flush_req_i,
    output logic      flush_ack_o,
    output logic      evict_req_o,
    output l2_set_t   evict_set_o,
    output l2_way_t   evict_way_o,
    input  logic      evict_ack_i,

    l2_reqs_if.ctrl   reqs,
    input  logic      put_i,
    input  reqs_idx_t put_idx_i,

    output logic      set_ongoing_flush_o,
    output logic      clr_ongoing_flush_o,
    output logic      set_set_conflict_o,
    output logic      clr_set_conflict_o,
    output logic      set_fwd_stall_o,
    output logic      clr_fwd_stall_o,
    output logic      set_ongoing_atomic_o,
    output logic      clr_ongoing_atomic_o,
    output logic      set_evict_stall_o,
    output logic      clr_evict_stall_o,
    output logic      set_flush_stall_ended_o,
    output logic      clr_flush_stall_ended_o,
    output logic      incr_flush_set_o,
    output logic      clr_flush_set_o,
    output logic      incr_flush_way_o,
    output logic      clr_flush_way_o,
    output logic      incr_reqs_cnt_o,
    output logic      clr_reqs_cnt_o,
    output logic      set_fwd_stall_i_o,
    output reqs_idx_t fwd_stall_i_wr_data_o,
    output logic      clr_fwd_stall_ended_o,

    input  logic      ongoing_flush_i,
    input  logic      set_conflict_i,
    input  logic      fwd_stall_i,
    input  logic      ongoing_atomic_i,
    input  logic      evict_stall_i,
    input  logic      flush_stall_ended_i,
    input  logic      fwd_stall_ended_i,
    input  l2_set_t   flush_set_i,
    input  l2_way_t   flush_way_i
);

    l2_state_t state;
    l2_state_t state_next;
    reqs_idx_t cpu_idx_q;
    reqs_idx_t atomic_idx_q;
    logic      idle_open;
    logic      cpu_accept;
    logic      fwd_start;
    logic      flush_start;
    logic      last_way;
    logic      last_line;

    assign idle_open   = state == IDLE && !ongoing_flush_i;
    assign cpu_accept  = idle_open && cpu_req_i
                         && !(reqs.full || ongoing_atomic_i || reqs.hit);
    assign fwd_start   = idle_open && !cpu_req_i && fwd_req_i;
    assign flush_start = state == IDLE && !cpu_req_i && !fwd_req_i && flush_req_i;

    // The CPU set is looked up whenever a CPU request is present.
    assign reqs.lookup_set = cpu_req_i ? cpu_set_i : fwd_set_i;
    assign reqs.alloc_set  = cpu_set_i;
    assign reqs.alloc      = cpu_accept;

    assign set_set_conflict_o    = idle_open && cpu_req_i && reqs.hit;
    assign clr_set_conflict_o    = set_conflict_i && cpu_accept;
    assign incr_reqs_cnt_o       = cpu_accept;
    assign set_ongoing_atomic_o  = cpu_accept && cpu_op_i == OP_ATOMIC;
    // Only a put after the atomic was recorded may end it.
    assign clr_ongoing_atomic_o  = ongoing_atomic_i && put_i && put_idx_i == atomic_idx_q;
    assign fwd_stall_i_wr_data_o = reqs.hit_idx;

    assign last_way  = flush_way_i == l2_way_t'(`L2_WAYS - 1);
    assign last_line = last_way && flush_set_i == l2_set_t'(`L2_SETS - 1);

    assign cpu_ack_o   = state == CPU_ACK;
    assign cpu_idx_o   = cpu_idx_q;
    assign fwd_ack_o   = state == FWD_ACK;
    assign flush_ack_o = state == FLUSH_ACK;
    assign evict_req_o = state == FLUSH_EVICT && evict_stall_i;
    assign evict_set_o = flush_set_i;
    assign evict_way_o = flush_way_i;

    always_comb begin
        state_next              = state;
        set_ongoing_flush_o     = 1'b0;
        clr_ongoing_flush_o     = 1'b0;
        set_fwd_stall_o         = 1'b0;
        clr_fwd_stall_o         = 1'b0;
        set_fwd_stall_i_o       = 1'b0;
        clr_fwd_stall_ended_o   = 1'b0;
        set_evict_stall_o       = 1'b0;
        clr_evict_stall_o       = 1'b0;
        set_flush_stall_ended_o = 1'b0;
        clr_flush_stall_ended_o = 1'b0;
        incr_flush_set_o        = 1'b0;
        clr_flush_set_o         = 1'b0;
        incr_flush_way_o        = 1'b0;
        clr_flush_way_o         = 1'b0;
        clr_reqs_cnt_o          = 1'b0;
        unique case (state)
            IDLE: begin
                if (cpu_accept) begin
                    state_next = CPU_ACK;
                end else if (fwd_start && reqs.hit) begin
                    set_fwd_stall_o   = 1'b1;
                    set_fwd_stall_i_o = 1'b1;
                    state_next        = FWD_WAIT;
                end else if (fwd_start) begin
                    state_next = FWD_ACK;
                end else if (flush_start) begin
                    set_ongoing_flush_o = 1'b1;
                    clr_flush_set_o     = 1'b1;
                    clr_flush_way_o     = 1'b1;
                    state_next          = FLUSH_DRAIN;
                end
            end
            CPU_ACK: begin
                if (!cpu_req_i) state_next = IDLE;
            end
            FWD_WAIT: begin
                if (fwd_stall_i && fwd_stall_ended_i) begin
                    clr_fwd_stall_o       = 1'b1;
                    clr_fwd_stall_ended_o = 1'b1;
                    state_next            = FWD_ACK;
                end
            end
            FWD_ACK: begin
                if (!fwd_req_i) state_next = IDLE;
            end
            FLUSH_DRAIN: begin
                if (flush_stall_ended_i) begin
                    clr_flush_stall_ended_o = 1'b1;
                    set_evict_stall_o       = 1'b1;  // Raises the first eviction.
                    state_next              = FLUSH_EVICT;
                end else if (reqs.empty) begin
                    set_flush_stall_ended_o = 1'b1;
                end
            end
            FLUSH_EVICT: begin
                if (evict_stall_i) begin
                    if (evict_ack_i) clr_evict_stall_o = 1'b1;
                end else if (!evict_ack_i) begin
                    incr_flush_way_o = 1'b1;
                    incr_flush_set_o = last_way;
                    if (last_line) state_next = FLUSH_ACK;
                    else set_evict_stall_o = 1'b1;
                end
            end
            FLUSH_ACK: begin
                if (!flush_req_i) begin
                    clr_ongoing_flush_o = 1'b1;
                    clr_reqs_cnt_o      = 1'b1;
                    state_next          = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_accept) cpu_idx_q <= reqs.alloc_idx;
        if (set_ongoing_atomic_o) atomic_idx_q <= reqs.alloc_idx;
    end

endmodule

// File: rtl/l2_reqs.sv
`include "cache_consts.svh"

module l2_reqs
    import l2_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    l2_reqs_if.tbl    reqs,
    input  logic      fill_req_i,
    input  reqs_idx_t fill_idx_i,
    output logic      fill_ack_o,
    output logic      put_o,
    output reqs_idx_t put_idx_o
);

    logic [`REQS-1:0] valid;
    l2_set_t          set_q [`REQS];
    logic             fill_take;

    assign fill_take  = fill_req_i && !fill_ack_o;  // First cycle of a fill request.
    assign reqs.full  = &valid;
    assign reqs.empty = ~|valid;

    // Scan downwards so the lowest free entry wins.
    always_comb begin
        reqs.alloc_idx = '0;
        for (int i = `REQS - 1; i >= 0; i--) begin
            if (!valid[i]) reqs.alloc_idx = reqs_idx_t'(i);
        end
    end

    // A set is pending in at most one entry, since conflicting requests stall.
    always_comb begin
        reqs.hit     = 1'b0;
        reqs.hit_idx = '0;
        for (int i = 0; i < `REQS; i++) begin
            if (valid[i] && set_q[i] == reqs.lookup_set) begin
                reqs.hit     = 1'b1;
                reqs.hit_idx = reqs_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid      <= '0;
            fill_ack_o <= 1'b0;
            put_o      <= 1'b0;
        end else begin
            if (reqs.alloc) valid[reqs.alloc_idx] <= 1'b1;
            if (fill_take && valid[fill_idx_i]) valid[fill_idx_i] <= 1'b0;
            put_o      <= fill_take && valid[fill_idx_i];  // A free entry gives no put.
            fill_ack_o <= fill_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reqs.alloc) set_q[reqs.alloc_idx] <= reqs.alloc_set;
        if (fill_take) put_idx_o <= fill_idx_i;
    end

endmodule

// File: rtl/l2_regs.sv
module l2_regs
    import l2_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      set_ongoing_flush_i,
    input  logic      clr_ongoing_flush_i,
    input  logic      set_set_conflict_i,
    input  logic      clr_set_conflict_i,
    input  logic      set_fwd_stall_i,
    input  logic      clr_fwd_stall_i,
    input  logic      set_ongoing_atomic_i,
    input  logic      clr_ongoing_atomic_i,
    input  logic      set_evict_stall_i,
    input  logic      clr_evict_stall_i,
    input  logic      set_flush_stall_ended_i,
    input  logic      clr_flush_stall_ended_i,

    input  logic      incr_flush_set_i,
    input  logic      clr_flush_set_i,
    input  logic      incr_flush_way_i,
    input  logic      clr_flush_way_i,
    input  logic      incr_reqs_cnt_i,
    input  logic      clr_reqs_cnt_i,

    input  logic      set_fwd_stall_i_i,
    input  reqs_idx_t fwd_stall_i_wr_data_i,
    input  logic      clr_fwd_stall_ended_i,
    input  logic      put_i,
    input  reqs_idx_t put_idx_i,

    output logic      ongoing_flush_o,
    output logic      set_conflict_o,
    output logic      fwd_stall_o,
    output logic      ongoing_atomic_o,
    output logic      evict_stall_o,
    output logic      flush_stall_ended_o,
    output logic      fwd_stall_ended_o,
    output l2_set_t   flush_set_o,
    output l2_way_t   flush_way_o,
    output reqs_cnt_t reqs_cnt_o
);

    reqs_idx_t fwd_stall_i;  // Entry a stalled forward waits on.

    // Each flag clears with priority over set.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ongoing_flush_o     <= 1'b0;
            set_conflict_o      <= 1'b0;
            fwd_stall_o         <= 1'b0;
            ongoing_atomic_o    <= 1'b0;
            evict_stall_o       <= 1'b0;
            flush_stall_ended_o <= 1'b0;
        end else begin
            if (clr_ongoing_flush_i) ongoing_flush_o <= 1'b0;
            else if (set_ongoing_flush_i) ongoing_flush_o <= 1'b1;

            if (clr_set_conflict_i) set_conflict_o <= 1'b0;
            else if (set_set_conflict_i) set_conflict_o <= 1'b1;

            if (clr_fwd_stall_i) fwd_stall_o <= 1'b0;
            else if (set_fwd_stall_i) fwd_stall_o <= 1'b1;

            if (clr_ongoing_atomic_i) ongoing_atomic_o <= 1'b0;
            else if (set_ongoing_atomic_i) ongoing_atomic_o <= 1'b1;

            if (clr_evict_stall_i) evict_stall_o <= 1'b0;
            else if (set_evict_stall_i) evict_stall_o <= 1'b1;

            if (clr_flush_stall_ended_i) flush_stall_ended_o <= 1'b0;
            else if (set_flush_stall_ended_i) flush_stall_ended_o <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_set_o <= '0;
            flush_way_o <= '0;
            reqs_cnt_o  <= '0;
        end else begin
            if (clr_flush_set_i) flush_set_o <= '0;
            else if (incr_flush_set_i) flush_set_o <= flush_set_o + 1'b1;

            if (clr_flush_way_i) flush_way_o <= '0;
            else if (incr_flush_way_i) flush_way_o <= flush_way_o + 1'b1;  // Wraps at the last way.

            if (clr_reqs_cnt_i) reqs_cnt_o <= '0;
            else if (incr_reqs_cnt_i) reqs_cnt_o <= reqs_cnt_o + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_stall_i       <= '0;
            fwd_stall_ended_o <= 1'b0;
        end else begin
            if (set_fwd_stall_i_i) fwd_stall_i <= fwd_stall_i_wr_data_i;

            if (clr_fwd_stall_ended_i) begin
                fwd_stall_ended_o <= 1'b0;
            end else if (put_i && fwd_stall_o && put_idx_i == fwd_stall_i) begin
                fwd_stall_ended_o <= 1'b1;  // The entry blocking the forward was released.
            end
        end
    end

endmodule

// File: rtl/l2_reqs_if.sv
interface l2_reqs_if
    import l2_types_pkg::*;
();

    logic      alloc;      // One cycle per accepted CPU request.
    l2_set_t   alloc_set;
    l2_set_t   lookup_set;
    reqs_idx_t alloc_idx;  // Lowest free entry.
    logic      hit;
    reqs_idx_t hit_idx;
    logic      full;
    logic      empty;

    modport ctrl (
        output alloc,
        output alloc_set,
        output lookup_set,
        input  alloc_idx,
        input  hit,
        input  hit_idx,
        input  full,
        input  empty
    );

    modport tbl (
        input  alloc,
        input  alloc_set,
        input  lookup_set,
        output alloc_idx,
        output hit,
        output hit_idx,
        output full,
        output empty
    );

endinterface

// File: rtl/l2_ctrl_pkg.sv
package l2_ctrl_pkg;

    typedef enum logic {
        OP_READ,
        OP_ATOMIC
    } cpu_op_t;

    typedef enum logic [2:0] {
        IDLE,
        CPU_ACK,
        FWD_WAIT,
        FWD_ACK,
        FLUSH_DRAIN,
        FLUSH_EVICT,
        FLUSH_ACK
    } l2_state_t;

endpackage

// File: rtl/l2_types_pkg.sv
`include "cache_consts.svh"

package l2_types_pkg;

    typedef logic [`L2_SET_BITS-1:0] l2_set_t;
    typedef logic [`L2_WAY_BITS-1:0] l2_way_t;
    typedef logic [`REQS_BITS-1:0] reqs_idx_t;     // Entry of the request table.
    typedef logic [`REQS_CNT_BITS-1:0] reqs_cnt_t;  // Requests accepted since the last flush.

endpackage

// File: include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Cache geometry.
`define L2_SETS 8
`define L2_SET_BITS 3
`define L2_WAYS 4
`define L2_WAY_BITS 2

// Request table sizing.
`define REQS 4
`define REQS_BITS 2
`define REQS_BITS_P1 3
`define REQS_CNT_BITS 8

`endif
